// File: design/fetch_pkg.sv
package fetch_pkg;

  // datapath and address width
  localparam int gpr_size = 64;

  // instruction memory, one 4 KiB page
  localparam int imem_bytes = 4096;
  localparam int imem_addr_bits = $clog2(imem_bytes);

  // boot address, loaded while reset is high
  localparam logic [gpr_size-1:0] entry_pc = 64'h0000_0000_0000_0100;

  // HLT #0, sent downstream on return from main
  localparam logic [31:0] insn_hlt = 32'hd440_0000;

  // top six bits of unconditional branches
  localparam logic [5:0] b_op_bits  = 6'b000101;
  localparam logic [5:0] bl_op_bits = 6'b100101;

  // B.cond top byte
  localparam logic [7:0] bcond_top_byte = 8'h54;

  // pc-relative address class, bits 28..24
  localparam logic [4:0] adr_class_bits = 5'b10000;

  // coarse opcode classes seen by fetch
  typedef enum logic [2:0] {
    op_b,
    op_bl,
    op_b_cond,
    op_adr,
    op_adrp,
    op_other
  } opcode_t;

  // unconditional branch layout
  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] imm26;
  } b_fmt_t;

  // ADR / ADRP layout
  // op picks page (1) or byte (0) granularity
  typedef struct packed {
    logic        op;
    logic [1:0]  immlo;
    logic [4:0]  cls;
    logic [18:0] immhi;
    logic [4:0]  rd;
  } adr_fmt_t;

  // one instruction word, three views of the same bits
  typedef union packed {
    logic [31:0] raw;
    b_fmt_t      b_fmt;
    adr_fmt_t    adr_fmt;
  } insn_u;

  // what the pc register does on the next edge
  typedef enum logic [2:0] {
    pc_hold,
    pc_seq,
    pc_jump,
    pc_entry,
    pc_redirect
  } pc_op_t;

  // fetch FSM states
  typedef enum logic [1:0] {
    st_reset,
    st_settle,
    st_run,
    st_halt
  } fetch_state_t;

  // mispredict from the reorder buffer, single-cycle strobe
  typedef struct packed {
    logic                valid;
    logic [gpr_size-1:0] pc;
  } redirect_t;

  // one fetched instruction toward decode
  typedef struct packed {
    logic                valid;
    logic [gpr_size-1:0] pc;
    insn_u               insn;
    opcode_t             opcode;
  } fetch_out_t;

endpackage

// File: design/imem.sv
`timescale 1ns/1ns

module imem
  import fetch_pkg::*;
(
  input  logic [gpr_size-1:0] pc,
  output insn_u               insn
);

  // byte storage, little-endian words
  logic [7:0] mem [imem_bytes];

  // byte addresses of the four lanes
  logic [imem_addr_bits-1:0] addr0;
  logic [imem_addr_bits-1:0] addr1;
  logic [imem_addr_bits-1:0] addr2;
  logic [imem_addr_bits-1:0] addr3;

  initial begin
    $readmemh("testbench/prog.hex", mem);
  end

  // only the low address bits index the page
  // lane addresses wrap inside the page
  always_comb begin
    addr0 = pc[imem_addr_bits-1:0];
    addr1 = addr0 + imem_addr_bits'(1);
    addr2 = addr0 + imem_addr_bits'(2);
    addr3 = addr0 + imem_addr_bits'(3);
  end

  // lowest address holds the least significant byte
  always_comb begin
    insn.raw = {mem[addr3], mem[addr2], mem[addr1], mem[addr0]};
  end

endmodule

// File: design/insn_decode.sv
`timescale 1ns/1ns

module insn_decode
  import fetch_pkg::*;
(
  input  insn_u               insn,
  output opcode_t             opcode,
  output logic [gpr_size-1:0] branch_offset
);

  // class match flags
  logic is_b;
  logic is_bl;
  logic is_b_cond;
  logic is_adr_class;

  // top bits of the word pick the class
  always_comb begin
    is_b         = insn.b_fmt.op == b_op_bits;
    is_bl        = insn.b_fmt.op == bl_op_bits;
    // B.cond only needs the top byte here
    is_b_cond    = insn.raw[31:24] == bcond_top_byte;
    // ADR and ADRP share the class field
    is_adr_class = insn.adr_fmt.cls == adr_class_bits;
  end

  // coarse opcode
  // the patterns do not overlap, order is only for readability
  always_comb begin
    if (is_b) begin
      opcode = op_b;
    end else if (is_bl) begin
      opcode = op_bl;
    end else if (is_b_cond) begin
      opcode = op_b_cond;
    end else if (is_adr_class) begin
      // op bit high means page granularity
      if (insn.adr_fmt.op) begin
        opcode = op_adrp;
      end else begin
        opcode = op_adr;
      end
    end else begin
      opcode = op_other;
    end
  end

  // imm26 is a word offset
  // scale to bytes and sign-extend to pc width
  // meaningful only for B and BL
  always_comb begin
    branch_offset = {
      {(gpr_size - 28){insn.b_fmt.imm26[25]}},
      insn.b_fmt.imm26,
      2'b00
    };
  end

endmodule

// File: design/pc_gen.sv
`timescale 1ns/1ns

module pc_gen
  import fetch_pkg::*;
(
  input  logic                in_clk,
  input  logic                in_rst,
  input  pc_op_t              pc_op,
  input  redirect_t           redirect,
  input  logic [gpr_size-1:0] branch_offset,
  output logic [gpr_size-1:0] pc
);

  logic [gpr_size-1:0] pc_next;

  // next pc
  always_comb begin
    case (pc_op)
      pc_seq:      pc_next = pc + gpr_size'(4);
      pc_jump:     pc_next = pc + branch_offset;
      pc_entry:    pc_next = entry_pc;
      pc_redirect: pc_next = redirect.pc;
      default:     pc_next = pc;
    endcase
  end

  // pc register
  always_ff @(posedge in_clk) begin
    pc <= pc_next;
  end

endmodule

// File: design/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic                in_clk,
  input  logic                in_rst,
  input  redirect_t           redirect,
  input  logic [gpr_size-1:0] pc,
  input  insn_u               insn,
  input  opcode_t             opcode,
  output pc_op_t              pc_op,
  output fetch_out_t          fetch_out
);

  fetch_state_t state;
  fetch_state_t state_next;

  // stop conditions
  logic pc_zero;
  logic word_zero;
  logic is_branch;

  always_comb begin
    // pc 0 is the return from main
    pc_zero   = pc == '0;
    // empty slot, no program
    word_zero = insn.raw == '0;
    // only B and BL are followed
    is_branch = (opcode == op_b) || (opcode == op_bl);
  end

  // next state, pc operation and output word
  always_comb begin
    state_next       = state;
    pc_op            = pc_hold;
    fetch_out.valid  = 1'b0;
    fetch_out.pc     = pc;
    fetch_out.insn   = insn;
    fetch_out.opcode = opcode;

    case (state)
      st_reset: begin
        // keep loading the boot address
        pc_op      = pc_entry;
        state_next = st_settle;
      end
      st_settle: begin
        // one idle cycle at the entry point
        pc_op      = pc_hold;
        state_next = st_run;
      end
      st_run: begin
        if (pc_zero) begin
          // emit HLT once, then stop
          fetch_out.valid    = 1'b1;
          fetch_out.insn.raw = insn_hlt;
          fetch_out.opcode   = op_other;
          pc_op              = pc_hold;
          state_next         = st_halt;
        end else if (word_zero) begin
          // ran off the program
          pc_op      = pc_hold;
          state_next = st_halt;
        end else begin
          fetch_out.valid = 1'b1;
          if (is_branch) begin
            pc_op = pc_jump;
          end else begin
            pc_op = pc_seq;
          end
        end
      end
      default: begin
        // halted, wait for a redirect
        pc_op = pc_hold;
      end
    endcase

    // mispredict wins over everything outside reset
    // this cycle's output is still the wrong-path word
    if (redirect.valid && (state != st_reset)) begin
      pc_op      = pc_redirect;
      state_next = st_run;
    end
  end

  // state register
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state <= st_reset;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ns

module fetch_top
  import fetch_pkg::*;
(
  input  logic       in_clk,
  input  logic       in_rst,
  input  redirect_t  redirect,
  output fetch_out_t fetch_out
);

  // internal nets
  logic [gpr_size-1:0] pc;
  insn_u               insn;
  opcode_t             opcode;
  logic [gpr_size-1:0] branch_offset;
  pc_op_t              pc_op;

  // FSM, picks the pc op and forms the output
  fetch_ctrl i_fetch_ctrl (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .redirect  (redirect),
    .pc        (pc),
    .insn      (insn),
    .opcode    (opcode),
    .pc_op     (pc_op),
    .fetch_out (fetch_out)
  );

  // pc register
  pc_gen i_pc_gen (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .pc_op         (pc_op),
    .redirect      (redirect),
    .branch_offset (branch_offset),
    .pc            (pc)
  );

  // combinational read of the current pc
  imem i_imem (
    .pc   (pc),
    .insn (insn)
  );

  // opcode class and branch offset
  insn_decode i_insn_decode (
    .insn          (insn),
    .opcode        (opcode),
    .branch_offset (branch_offset)
  );

endmodule

// File: testbench/fetch_sva.sv
`timescale 1ns/1ns

module fetch_sva
  import fetch_pkg::*;
(
  input logic                in_clk,
  input logic                in_rst,
  input fetch_state_t        state,
  input redirect_t           redirect,
  input logic [gpr_size-1:0] pc,
  input fetch_out_t          fetch_out
);

  // nothing leaves fetch before run
  no_valid_early: assert property (@(posedge in_clk)
    (state == st_reset || state == st_settle) |-> !fetch_out.valid)
    else $error("valid high in reset or settle state");

  // mispredict always restarts fetch
  redirect_to_run: assert property (@(posedge in_clk) disable iff (in_rst)
    (redirect.valid && state != st_reset) |=> state == st_run)
    else $error("redirect strobe not followed by run state");

  // halted fetch is silent
  no_valid_halt: assert property (@(posedge in_clk) disable iff (in_rst)
    state == st_halt |-> !fetch_out.valid)
    else $error("valid high in halt state");

  // HLT only stands for return from main
  hlt_at_zero: assert property (@(posedge in_clk) disable iff (in_rst)
    (fetch_out.valid && fetch_out.insn.raw == insn_hlt) |-> pc == '0)
    else $error("HLT emitted at nonzero pc");

endmodule

// File: testbench/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb
  import fetch_pkg::*;
();

  localparam int clk_period      = 20;
  localparam int reset_cycles    = 4;
  localparam int boot_budget     = 30;
  localparam int idle_cycles     = 8;
  localparam int redirect_budget = 24;
  localparam int margin_cycles   = 40;
  // boot, idle, three redirect tests and slack
  localparam int watchdog_cycles = reset_cycles + boot_budget + idle_cycles
                                   + 3 * (redirect_budget + 8) + margin_cycles;
  // redirect targets, words 0x100 to 0x12c
  localparam int target_words = 12;

  logic       in_clk = 1'b0;
  logic       in_rst;
  redirect_t  redirect;
  fetch_out_t fetch_out;

  // own copy of the program image
  logic [7:0] tb_mem [imem_bytes];

  // model of fetch, advanced by the compare process
  fetch_state_t        m_state = st_reset;
  logic [gpr_size-1:0] m_pc = entry_pc;
  logic [31:0]         exp_word;
  opcode_t             exp_op;
  logic                exp_valid;
  logic [gpr_size-1:0] exp_next;
  logic                exp_stop;

  // observed events, written by the compare process only
  logic [5:0] seen_op = '0;
  logic       seen_fwd_b = 1'b0;
  logic       seen_back_b = 1'b0;
  int         valid_count = 0;
  int         wrong_path_count = 0;
  int         hlt_count = 0;
  int         check_errs = 0;

  // bookkeeping of the stimulus process
  string  cur_test = "none";
  int     stim_errs = 0;
  int     test_err_start = 0;
  int     pass_tests = 0;
  int     fail_tests = 0;
  integer seed;

  fetch_top i_dut (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .redirect  (redirect),
    .fetch_out (fetch_out)
  );

  bind fetch_ctrl fetch_sva i_fetch_sva (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .state     (state),
    .redirect  (redirect),
    .pc        (pc),
    .fetch_out (fetch_out)
  );

  always #(clk_period / 2) in_clk = ~in_clk;

  // little-endian word at the low address bits
  function automatic logic [31:0] read_word(input logic [gpr_size-1:0] pc);
    logic [imem_addr_bits-1:0] a;
    a = pc[imem_addr_bits-1:0];
    return {tb_mem[a + imem_addr_bits'(3)], tb_mem[a + imem_addr_bits'(2)],
            tb_mem[a + imem_addr_bits'(1)], tb_mem[a]};
  endfunction

  // expected output and next pc for one run cycle
  function automatic void ref_fetch(
    input  logic [gpr_size-1:0] pc,
    output logic [31:0]         word,
    output opcode_t             op,
    output logic                valid,
    output logic [gpr_size-1:0] next_pc,
    output logic                stop
  );
    logic signed [gpr_size-1:0] offset;
    word    = read_word(pc);
    op      = op_other;
    valid   = 1'b1;
    next_pc = pc + 64'd4;
    stop    = 1'b0;
    // imm26 counts words
    offset  = 64'($signed(word[25:0])) * 64'sd4;
    if (pc == 64'd0) begin
      // return from main
      word    = insn_hlt;
      next_pc = pc;
      stop    = 1'b1;
    end else if (word == 32'd0) begin
      valid   = 1'b0;
      next_pc = pc;
      stop    = 1'b1;
    end else if (word[31:26] == 6'b000101) begin
      op      = op_b;
      next_pc = pc + offset;
    end else if (word[31:26] == 6'b100101) begin
      op      = op_bl;
      next_pc = pc + offset;
    end else if (word[31:24] == 8'h54) begin
      op = op_b_cond;
    end else if (word[28:24] == 5'b10000) begin
      // bit 31 set for the page form
      op = word[31] ? op_adrp : op_adr;
    end
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
      check_errs++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("%s", msg);
    stim_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = check_errs + stim_errs;
  endtask

  task automatic end_test();
    int errs;
    errs = check_errs + stim_errs - test_err_start;
    if (errs == 0) begin
      pass_tests++;
      $display("test %s passed", cur_test);
    end else begin
      fail_tests++;
      $display("test %s failed with %0d errors", cur_test, errs);
    end
  endtask

  // one-cycle strobe, driven on rising edges
  task automatic send_redirect(input logic [gpr_size-1:0] target);
    @(posedge in_clk);
    redirect <= {1'b1, target};
    @(posedge in_clk);
    redirect <= '0;
  endtask

  // random word inside the program
  task automatic pick_target(output logic [gpr_size-1:0] target);
    int unsigned idx;
    idx    = $unsigned($random(seed)) % target_words;
    target = entry_pc + 64'(idx * 4);
  endtask

  task automatic wait_halt(input int budget);
    int n;
    n = 0;
    @(negedge in_clk);
    while (i_dut.i_fetch_ctrl.state != st_halt && n < budget) begin
      @(negedge in_clk);
      n++;
    end
    if (i_dut.i_fetch_ctrl.state != st_halt) begin
      note_error($sformatf("test %s: fetch did not halt within %0d cycles", cur_test, budget));
    end
  endtask

  // compare at mid-cycle, then step the model across the next edge
  always @(negedge in_clk) begin
    ref_fetch(m_pc, exp_word, exp_op, exp_valid, exp_next, exp_stop);
    if (m_state != st_run) begin
      exp_valid = 1'b0;
    end
    check("valid", {63'd0, exp_valid}, {63'd0, fetch_out.valid});
    check("pc", m_pc, fetch_out.pc);
    if (exp_valid) begin
      check("insn", {32'd0, exp_word}, {32'd0, fetch_out.insn.raw});
      check("opcode", 64'(exp_op), 64'(fetch_out.opcode));
      seen_op[exp_op] = 1'b1;
      if (exp_op == op_b && exp_next > m_pc) begin
        seen_fwd_b = 1'b1;
      end
      if (exp_op == op_b && exp_next < m_pc) begin
        seen_back_b = 1'b1;
      end
    end
    if (fetch_out.valid) begin
      valid_count++;
      if (redirect.valid) begin
        wrong_path_count++;
      end
      if (fetch_out.insn.raw == insn_hlt) begin
        hlt_count++;
      end
    end
    // next state, redirect first
    if (in_rst) begin
      m_state = st_reset;
      m_pc    = entry_pc;
    end else if (redirect.valid && m_state != st_reset) begin
      m_state = st_run;
      m_pc    = redirect.pc;
    end else begin
      case (m_state)
        st_reset:  m_state = st_settle;
        st_settle: m_state = st_run;
        st_run: begin
          m_pc = exp_next;
          if (exp_stop) begin
            m_state = st_halt;
          end
        end
        default: m_state = st_halt;
      endcase
    end
  end

  initial begin
    logic [gpr_size-1:0] target;
    int                  snap;
    seed = 32'hf27a_12f4;
    in_rst   <= 1'b1;
    redirect <= '0;
    $readmemh("testbench/prog.hex", tb_mem);

    begin_test("boot_and_branches");
    repeat (reset_cycles) @(posedge in_clk);
    in_rst <= 1'b0;
    wait_halt(boot_budget);
    if (!(seen_fwd_b && seen_back_b && seen_op[op_bl])) begin
      note_error("boot_and_branches: a forward B, a backward B or a BL was never fetched");
    end
    if (!(seen_op[op_b_cond] && seen_op[op_adr] && seen_op[op_adrp])) begin
      note_error("boot_and_branches: B.cond, ADR or ADRP was never fetched");
    end
    end_test();

    begin_test("halt_idle");
    snap = valid_count;
    repeat (idle_cycles) @(negedge in_clk);
    if (valid_count != snap) begin
      note_error("halt_idle: a valid output appeared while fetch was halted");
    end
    end_test();

    begin_test("redirect_halted");
    pick_target(target);
    send_redirect(target);
    wait_halt(redirect_budget);
    end_test();

    begin_test("redirect_midstream");
    snap = wrong_path_count;
    send_redirect(entry_pc);
    repeat (2) @(posedge in_clk);
    pick_target(target);
    send_redirect(target);
    wait_halt(redirect_budget);
    if (wrong_path_count == snap) begin
      note_error("redirect_midstream: no wrong-path word was emitted in the strobe cycle");
    end
    end_test();

    begin_test("return_main");
    snap = hlt_count;
    send_redirect(64'd0);
    wait_halt(redirect_budget);
    repeat (4) @(negedge in_clk);
    if (hlt_count - snap != 1) begin
      note_error($sformatf("return_main: HLT was emitted %0d times", hlt_count - snap));
    end
    end_test();

    $display("tests passed: %0d failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && check_errs == 0 && stim_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles in test %s", watchdog_cycles, cur_test);
    $display("Test failed");
    $finish;
  end

endmodule

// File: testbench/prog.hex
// one byte per column, four bytes per line, lowest address first
// @ lines give the byte address of the next line
@000
1f 20 03 d5  // 0x000 nop, replaced by HLT on return from main
@100
1f 20 03 d5  // 0x100 nop, entry point
00 04 00 91  // 0x104 add x0, x0, #1
40 00 00 54  // 0x108 b.eq +8, falls through
01 00 00 10  // 0x10c adr x1, 0
02 00 00 90  // 0x110 adrp x2, 0
03 00 00 14  // 0x114 b +12 to 0x120
1f 20 03 d5  // 0x118 nop, skipped
1f 20 03 d5  // 0x11c nop, skipped
08 00 00 94  // 0x120 bl +32 to 0x140
1f 20 03 d5  // 0x124 nop, skipped
1f 20 03 d5  // 0x128 nop, backward target
00 04 00 f1  // 0x12c subs x0, x0, #1
00 00 00 00  // 0x130 empty word, fetch stops
00 00 00 00  // 0x134
00 00 00 00  // 0x138
00 00 00 00  // 0x13c
a3 00 80 d2  // 0x140 movz x3, #5
f9 ff ff 17  // 0x144 b -28 to 0x128

// File: all.f
design/fetch_pkg.sv
design/imem.sv
design/insn_decode.sv
design/pc_gen.sv
design/fetch_ctrl.sv
design/fetch_top.sv
testbench/fetch_sva.sv
testbench/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
